//--- hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] xlen_t;
	typedef logic [4:0]  reg_idx_t;

	// Primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_ADDIU   = 6'h09,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_e;

	// Function codes under OP_SPECIAL, instr[5:0]
	typedef enum logic [5:0] {
		F_SLL  = 6'h00,
		F_JR   = 6'h08,
		F_ADDU = 6'h21,
		F_SUBU = 6'h23,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_SLT  = 6'h2a
	} funct_e;

	// ALU_ADD must stay at zero so a cleared ctrl_t is a harmless add
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_SLT = 4'd4,
		ALU_SLL = 4'd5,
		ALU_LUI = 4'd6
	} alu_op_e;

	typedef enum logic [1:0] {
		FWD_RF  = 2'd0,
		FWD_EX  = 2'd1,
		FWD_MEM = 2'd2,
		FWD_WB  = 2'd3
	} fwd_sel_e;

	typedef struct packed {
		logic    reg_write;
		logic    reg_dst;
		logic    mem_read;
		logic    mem_write;
		logic    mem_to_reg;
		logic    alu_src;
		logic    is_branch;
		logic    is_jump;
		logic    jump_reg;
		logic    is_link;
		alu_op_e alu_op;
	} ctrl_t;

	////////////////////////////////////////////////////////////////////////////
	// Stage payloads
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		xlen_t pc_next;
		xlen_t instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t    ctrl;
		xlen_t    pc_next;
		xlen_t    rs_data;
		xlen_t    rt_data;
		xlen_t    imm;
		xlen_t    jump_target;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		reg_idx_t shamt;
	} id_ex_t;

	typedef struct packed {
		ctrl_t    ctrl;
		xlen_t    ex_result;
		xlen_t    store_data;
		reg_idx_t wreg;
	} ex_mem_t;

	typedef struct packed {
		logic     reg_write;
		xlen_t    wdata;
		reg_idx_t wreg;
	} mem_wb_t;

	// Observation events
	typedef struct packed {
		reg_idx_t wreg;
		xlen_t    wdata;
	} wb_event_t;

	typedef struct packed {
		xlen_t addr;
		xlen_t data;
	} store_event_t;

endpackage

`default_nettype wire

//--- hdl/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  wire logic     clk,
	input  wire logic     rst_n,
	input  wire logic     en,
	input  wire logic     flush,
	input  wire payload_t d,
	output payload_t      q
);

	// A cleared payload carries no write or memory enables
	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			q <= '0;
		end else if (en) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

//--- hdl/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input  wire cpu_pkg::xlen_t instr,
	output cpu_pkg::ctrl_t      ctrl
);

	cpu_pkg::opcode_e opcode;
	cpu_pkg::funct_e  funct;

	assign opcode = cpu_pkg::opcode_e'(instr[31:26]);
	assign funct  = cpu_pkg::funct_e'(instr[5:0]);

	always_comb begin
		ctrl = '0;
		case (opcode)
			cpu_pkg::OP_SPECIAL: begin
				case (funct)
					cpu_pkg::F_ADDU: ctrl.alu_op = cpu_pkg::ALU_ADD;
					cpu_pkg::F_SUBU: ctrl.alu_op = cpu_pkg::ALU_SUB;
					cpu_pkg::F_AND:  ctrl.alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::F_OR:   ctrl.alu_op = cpu_pkg::ALU_OR;
					cpu_pkg::F_SLT:  ctrl.alu_op = cpu_pkg::ALU_SLT;
					cpu_pkg::F_SLL:  ctrl.alu_op = cpu_pkg::ALU_SLL;
					default:         ctrl.alu_op = cpu_pkg::ALU_ADD;
				endcase
				if (funct == cpu_pkg::F_JR) begin
					ctrl.is_jump  = 1'b1;
					ctrl.jump_reg = 1'b1;
				end else if (ctrl.alu_op != cpu_pkg::ALU_ADD || funct == cpu_pkg::F_ADDU) begin
					// R-type result goes to rd
					ctrl.reg_write = 1'b1;
					ctrl.reg_dst   = 1'b1;
				end
			end
			cpu_pkg::OP_ADDIU: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
			end
			cpu_pkg::OP_LUI: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.alu_op    = cpu_pkg::ALU_LUI;
			end
			cpu_pkg::OP_LW: begin
				ctrl.reg_write  = 1'b1;
				ctrl.alu_src    = 1'b1;
				ctrl.mem_read   = 1'b1;
				ctrl.mem_to_reg = 1'b1;
			end
			cpu_pkg::OP_SW: begin
				ctrl.alu_src   = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			cpu_pkg::OP_BEQ: ctrl.is_branch = 1'b1;
			cpu_pkg::OP_J:   ctrl.is_jump   = 1'b1;
			cpu_pkg::OP_JAL: begin
				ctrl.is_jump   = 1'b1;
				ctrl.is_link   = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  wire logic             clk,
	input  wire logic             rst_n,
	input  wire cpu_pkg::reg_idx_t rs,
	input  wire cpu_pkg::reg_idx_t rt,
	output cpu_pkg::xlen_t        rs_data,
	output cpu_pkg::xlen_t        rt_data,
	input  wire logic             we,
	input  wire cpu_pkg::reg_idx_t wreg,
	input  wire cpu_pkg::xlen_t   wdata
);

	// Register 0 has no storage
	cpu_pkg::xlen_t regs [1:31];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wreg != '0) begin
			regs[wreg] <= wdata;
		end
	end

	// Old value on a same-cycle write, WB forwarding covers it
	assign rs_data = (rs == '0) ? '0 : regs[rs];
	assign rt_data = (rt == '0) ? '0 : regs[rt];

endmodule

`default_nettype wire

//--- hdl/fwd_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fwd_unit (
	input  wire cpu_pkg::reg_idx_t rs,
	input  wire cpu_pkg::reg_idx_t rt,
	input  wire cpu_pkg::reg_idx_t ex_dst,
	input  wire cpu_pkg::reg_idx_t mem_dst,
	input  wire cpu_pkg::reg_idx_t wb_dst,
	input  wire logic             ex_rw,
	input  wire logic             mem_rw,
	input  wire logic             wb_rw,
	output cpu_pkg::fwd_sel_e     sel_rs,
	output cpu_pkg::fwd_sel_e     sel_rt
);

	// Oldest first so the youngest matching stage overrides
	function automatic cpu_pkg::fwd_sel_e pick(input cpu_pkg::reg_idx_t src);
		cpu_pkg::fwd_sel_e sel;
		sel = cpu_pkg::FWD_RF;
		if (src != '0) begin
			if (wb_rw && wb_dst == src) begin
				sel = cpu_pkg::FWD_WB;
			end
			if (mem_rw && mem_dst == src) begin
				sel = cpu_pkg::FWD_MEM;
			end
			if (ex_rw && ex_dst == src) begin
				sel = cpu_pkg::FWD_EX;
			end
		end
		return sel;
	endfunction

	always_comb begin
		sel_rs = pick(rs);
		sel_rt = pick(rt);
	end

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire cpu_pkg::alu_op_e  op,
	input  wire cpu_pkg::xlen_t    a,
	input  wire cpu_pkg::xlen_t    b,
	input  wire cpu_pkg::reg_idx_t shamt,
	output cpu_pkg::xlen_t         result,
	output logic                   zero
);

	always_comb begin
		case (op)
			cpu_pkg::ALU_ADD: begin
				result = a + b;
			end
			cpu_pkg::ALU_SUB: begin
				result = a - b;
			end
			cpu_pkg::ALU_AND: begin
				result = a & b;
			end
			cpu_pkg::ALU_OR: begin
				result = a | b;
			end
			cpu_pkg::ALU_SLT: begin
				// Signed compare
				result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			end
			cpu_pkg::ALU_SLL: begin
				result = b << shamt;
			end
			cpu_pkg::ALU_LUI: begin
				result = {b[15:0], 16'h0000};
			end
			default: begin
				result = '0;
			end
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

//--- hdl/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
	input  wire cpu_pkg::ctrl_t ctrl,
	input  wire cpu_pkg::xlen_t pc_next,
	input  wire cpu_pkg::xlen_t imm,
	input  wire cpu_pkg::xlen_t rs_data,
	input  wire cpu_pkg::xlen_t rt_data,
	input  wire cpu_pkg::xlen_t jump_target,
	output logic                redirect,
	output cpu_pkg::xlen_t      target
);

	logic           taken;
	cpu_pkg::xlen_t branch_target;

	// beq compares here, no ALU flag needed
	assign taken         = ctrl.is_branch && (rs_data == rt_data);
	assign branch_target = pc_next + {imm[29:0], 2'b00};

	assign redirect = taken || ctrl.is_jump;

	always_comb begin
		if (ctrl.is_jump) begin
			target = ctrl.jump_reg ? rs_data : jump_target;
		end else begin
			target = branch_target;
		end
	end

endmodule

`default_nettype wire

//--- hdl/ram.sv
`timescale 1ns/1ps
`default_nettype none

module ram #(
	parameter int unsigned WORDS = 256
) (
	input  wire logic           clk,
	input  wire logic           we,
	input  wire cpu_pkg::xlen_t addr,
	input  wire cpu_pkg::xlen_t wdata,
	output cpu_pkg::xlen_t      rdata
);

	localparam int unsigned AW = (WORDS > 1) ? $clog2(WORDS) : 1;

	cpu_pkg::xlen_t  mem [WORDS];
	logic [AW-1:0]   idx;

	// Byte address to word index, wrapped to depth
	assign idx = AW'((addr >> 2) % WORDS);

	always_ff @(posedge clk) begin
		if (we) begin
			mem[idx] <= wdata;
		end
	end

	assign rdata = mem[idx];

endmodule

`default_nettype wire

//--- hdl/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu #(
	parameter int unsigned    IMEM_WORDS = 256,
	parameter int unsigned    DMEM_WORDS = 256,
	parameter cpu_pkg::xlen_t RESET_PC   = '0
) (
	input  wire logic             clk,
	input  wire logic             rst_n,
	input  wire logic             imem_load_en,
	input  wire cpu_pkg::xlen_t   imem_load_addr,
	input  wire cpu_pkg::xlen_t   imem_load_data,
	output logic                  wb_valid,
	output cpu_pkg::wb_event_t    wb,
	output logic                  store_valid,
	output cpu_pkg::store_event_t store
);

	cpu_pkg::xlen_t    pc;
	cpu_pkg::xlen_t    pc_plus4;
	cpu_pkg::xlen_t    imem_addr;
	cpu_pkg::xlen_t    if_instr;
	logic              imem_we;
	cpu_pkg::if_id_t   if_id_d;
	cpu_pkg::if_id_t   if_id_q;
	cpu_pkg::ctrl_t    id_ctrl;
	cpu_pkg::xlen_t    rf_rs_data;
	cpu_pkg::xlen_t    rf_rt_data;
	cpu_pkg::fwd_sel_e sel_rs;
	cpu_pkg::fwd_sel_e sel_rt;
	cpu_pkg::id_ex_t   id_ex_d;
	cpu_pkg::id_ex_t   id_ex_q;
	cpu_pkg::xlen_t    alu_b;
	cpu_pkg::xlen_t    alu_result;
	cpu_pkg::xlen_t    ex_result;
	cpu_pkg::reg_idx_t ex_wreg;
	logic              redirect;
	cpu_pkg::xlen_t    ex_target;
	cpu_pkg::ex_mem_t  ex_mem_d;
	cpu_pkg::ex_mem_t  ex_mem_q;
	cpu_pkg::xlen_t    dmem_rdata;
	cpu_pkg::xlen_t    mem_wdata;
	cpu_pkg::mem_wb_t  mem_wb_d;
	cpu_pkg::mem_wb_t  mem_wb_q;

	function automatic cpu_pkg::xlen_t fwd_mux(
		input cpu_pkg::fwd_sel_e sel,
		input cpu_pkg::xlen_t    rf,
		input cpu_pkg::xlen_t    ex,
		input cpu_pkg::xlen_t    mem,
		input cpu_pkg::xlen_t    wbv
	);
		case (sel)
			cpu_pkg::FWD_EX:  return ex;
			cpu_pkg::FWD_MEM: return mem;
			cpu_pkg::FWD_WB:  return wbv;
			default:          return rf;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Fetch
	////////////////////////////////////////////////////////////////////////////

	assign pc_plus4 = pc + 32'd4;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= RESET_PC;
		end else begin
			pc <= redirect ? ex_target : pc_plus4;
		end
	end

	// Load port owns the imem only while the core is in reset
	assign imem_we   = imem_load_en && !rst_n;
	assign imem_addr = rst_n ? pc : imem_load_addr;

	ram #(.WORDS(IMEM_WORDS)) imem (
		.clk   (clk),
		.we    (imem_we),
		.addr  (imem_addr),
		.wdata (imem_load_data),
		.rdata (if_instr)
	);

	assign if_id_d = '{pc_next: pc_plus4, instr: if_instr};

	pipe_reg #(.payload_t(cpu_pkg::if_id_t)) if_id (
		.clk(clk), .rst_n(rst_n), .en(1'b1), .flush(redirect), .d(if_id_d), .q(if_id_q)
	);

	////////////////////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////////////////////

	decoder u_decoder (
		.instr (if_id_q.instr),
		.ctrl  (id_ctrl)
	);

	regfile u_regfile (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs      (if_id_q.instr[25:21]),
		.rt      (if_id_q.instr[20:16]),
		.rs_data (rf_rs_data),
		.rt_data (rf_rt_data),
		.we      (mem_wb_q.reg_write),
		.wreg    (mem_wb_q.wreg),
		.wdata   (mem_wb_q.wdata)
	);

	// Loads in EX have no data yet
	fwd_unit u_fwd (
		.rs      (if_id_q.instr[25:21]),
		.rt      (if_id_q.instr[20:16]),
		.ex_dst  (ex_wreg),
		.mem_dst (ex_mem_q.wreg),
		.wb_dst  (mem_wb_q.wreg),
		.ex_rw   (id_ex_q.ctrl.reg_write && !id_ex_q.ctrl.mem_read),
		.mem_rw  (ex_mem_q.ctrl.reg_write),
		.wb_rw   (mem_wb_q.reg_write),
		.sel_rs  (sel_rs),
		.sel_rt  (sel_rt)
	);

	always_comb begin
		id_ex_d.ctrl        = id_ctrl;
		id_ex_d.pc_next     = if_id_q.pc_next;
		id_ex_d.rs_data     = fwd_mux(sel_rs, rf_rs_data, ex_result, mem_wdata, mem_wb_q.wdata);
		id_ex_d.rt_data     = fwd_mux(sel_rt, rf_rt_data, ex_result, mem_wdata, mem_wb_q.wdata);
		id_ex_d.imm         = {{16{if_id_q.instr[15]}}, if_id_q.instr[15:0]};
		id_ex_d.jump_target = {if_id_q.pc_next[31:28], if_id_q.instr[25:0], 2'b00};
		id_ex_d.rs          = if_id_q.instr[25:21];
		id_ex_d.rt          = if_id_q.instr[20:16];
		id_ex_d.rd          = if_id_q.instr[15:11];
		id_ex_d.shamt       = if_id_q.instr[10:6];
	end

	pipe_reg #(.payload_t(cpu_pkg::id_ex_t)) id_ex (
		.clk(clk), .rst_n(rst_n), .en(1'b1), .flush(redirect), .d(id_ex_d), .q(id_ex_q)
	);

	////////////////////////////////////////////////////////////////////////////
	// Execute
	////////////////////////////////////////////////////////////////////////////

	assign alu_b = id_ex_q.ctrl.alu_src ? id_ex_q.imm : id_ex_q.rt_data;

	alu u_alu (
		.op     (id_ex_q.ctrl.alu_op),
		.a      (id_ex_q.rs_data),
		.b      (alu_b),
		.shamt  (id_ex_q.shamt),
		.result (alu_result),
		.zero   ()
	);

	branch_unit u_branch (
		.ctrl        (id_ex_q.ctrl),
		.pc_next     (id_ex_q.pc_next),
		.imm         (id_ex_q.imm),
		.rs_data     (id_ex_q.rs_data),
		.rt_data     (id_ex_q.rt_data),
		.jump_target (id_ex_q.jump_target),
		.redirect    (redirect),
		.target      (ex_target)
	);

	// jal links to the next sequential address
	assign ex_result = id_ex_q.ctrl.is_link ? id_ex_q.pc_next : alu_result;

	always_comb begin
		if (id_ex_q.ctrl.is_link) begin
			ex_wreg = 5'd31;
		end else if (id_ex_q.ctrl.reg_dst) begin
			ex_wreg = id_ex_q.rd;
		end else begin
			ex_wreg = id_ex_q.rt;
		end
	end

	assign ex_mem_d = '{
		ctrl:       id_ex_q.ctrl,
		ex_result:  ex_result,
		store_data: id_ex_q.rt_data,
		wreg:       ex_wreg
	};

	pipe_reg #(.payload_t(cpu_pkg::ex_mem_t)) ex_mem (
		.clk(clk), .rst_n(rst_n), .en(1'b1), .flush(1'b0), .d(ex_mem_d), .q(ex_mem_q)
	);

	////////////////////////////////////////////////////////////////////////////
	// Memory and writeback
	////////////////////////////////////////////////////////////////////////////

	ram #(.WORDS(DMEM_WORDS)) dmem (
		.clk   (clk),
		.we    (ex_mem_q.ctrl.mem_write),
		.addr  (ex_mem_q.ex_result),
		.wdata (ex_mem_q.store_data),
		.rdata (dmem_rdata)
	);

	assign mem_wdata = ex_mem_q.ctrl.mem_to_reg ? dmem_rdata : ex_mem_q.ex_result;

	assign mem_wb_d = '{
		reg_write: ex_mem_q.ctrl.reg_write,
		wdata:     mem_wdata,
		wreg:      ex_mem_q.wreg
	};

	pipe_reg #(.payload_t(cpu_pkg::mem_wb_t)) mem_wb (
		.clk(clk), .rst_n(rst_n), .en(1'b1), .flush(1'b0), .d(mem_wb_d), .q(mem_wb_q)
	);

	// Observation, writes to r0 are hidden
	assign wb_valid    = mem_wb_q.reg_write && (mem_wb_q.wreg != '0);
	assign wb          = '{wreg: mem_wb_q.wreg, wdata: mem_wb_q.wdata};
	assign store_valid = ex_mem_q.ctrl.mem_write;
	assign store       = '{addr: ex_mem_q.ex_result, data: ex_mem_q.store_data};

endmodule

`default_nettype wire

//--- dv/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

	localparam int         VEC_DEPTH    = 128;
	localparam int         NUM_TESTS    = 6;
	localparam int         WAIT_CYCLES  = 100;
	localparam int         DRAIN_CYCLES = 24;
	localparam int         RESET_CYCLES = 8;
	localparam logic [3:0] KIND_PROG    = 4'h1;
	localparam logic [3:0] KIND_WB      = 4'h2;
	localparam logic [3:0] KIND_STORE   = 4'h3;

	// One vector line: kind, test tag, then two data words
	typedef struct packed {
		logic [3:0]     kind;
		logic [3:0]     test;
		cpu_pkg::xlen_t a;
		cpu_pkg::xlen_t b;
	} vec_t;

	logic                  clk;
	logic                  rst_n;
	logic                  imem_load_en;
	cpu_pkg::xlen_t        imem_load_addr;
	cpu_pkg::xlen_t        imem_load_data;
	logic                  wb_valid;
	cpu_pkg::wb_event_t    wb;
	logic                  store_valid;
	cpu_pkg::store_event_t store;

	logic [71:0]           vec_mem [VEC_DEPTH];
	cpu_pkg::wb_event_t    wb_q [$];
	cpu_pkg::store_event_t store_q [$];
	int                    pass_count;
	int                    fail_count;

	cpu #(
		.IMEM_WORDS (64),
		.DMEM_WORDS (64),
		.RESET_PC   (32'h0000_0000)
	) uut (
		.clk            (clk),
		.rst_n          (rst_n),
		.imem_load_en   (imem_load_en),
		.imem_load_addr (imem_load_addr),
		.imem_load_data (imem_load_data),
		.wb_valid       (wb_valid),
		.wb             (wb),
		.store_valid    (store_valid),
		.store          (store)
	);

	initial begin
		clk = 1'b0;
	end

	always #4 clk = ~clk;

	// Retirement monitor, mid-cycle so the strobes are settled
	always @(negedge clk) begin
		if (wb_valid === 1'b1) begin
			wb_q.push_back(wb);
		end
		if (store_valid === 1'b1) begin
			store_q.push_back(store);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic string test_name(input int t);
		case (t)
			1: return "alu and immediates";
			2: return "forwarding";
			3: return "store and load";
			4: return "beq taken and not taken";
			5: return "jal and jr";
			6: return "register zero";
			default: return "unknown";
		endcase
	endfunction

	task automatic load_program(output int count);
		vec_t v;
		count = 0;
		for (int i = 0; i < VEC_DEPTH; i++) begin
			v = vec_mem[i];
			if (v.kind == KIND_PROG) begin
				@(negedge clk);
				imem_load_en   = 1'b1;
				imem_load_addr = v.a;
				imem_load_data = v.b;
				count++;
			end
		end
		@(negedge clk);
		imem_load_en = 1'b0;
	endtask

	task automatic wait_for_wb(output bit seen);
		int cycles;
		cycles = 0;
		while (wb_q.size() == 0 && cycles < WAIT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		seen = (wb_q.size() != 0);
	endtask

	task automatic wait_for_store(output bit seen);
		int cycles;
		cycles = 0;
		while (store_q.size() == 0 && cycles < WAIT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		seen = (store_q.size() != 0);
	endtask

	task automatic check_wb(
		input cpu_pkg::wb_event_t exp,
		input cpu_pkg::wb_event_t got,
		input int                 t,
		inout int                 errs
	);
		if (got.wreg !== exp.wreg) begin
			$display("MISMATCH wb.wreg test %0d: expected %h, got %h", t, exp.wreg, got.wreg);
			errs++;
		end
		if (got.wdata !== exp.wdata) begin
			$display("MISMATCH wb.wdata test %0d: expected %h, got %h", t, exp.wdata, got.wdata);
			errs++;
		end
	endtask

	task automatic check_store(
		input cpu_pkg::store_event_t exp,
		input cpu_pkg::store_event_t got,
		input int                    t,
		inout int                    errs
	);
		if (got.addr !== exp.addr) begin
			$display("MISMATCH store.addr test %0d: expected %h, got %h", t, exp.addr, got.addr);
			errs++;
		end
		if (got.data !== exp.data) begin
			$display("MISMATCH store.data test %0d: expected %h, got %h", t, exp.data, got.data);
			errs++;
		end
	endtask

	// Writes and stores each retire in program order, so each queue is
	// checked in file order within the test
	task automatic run_test(input int t);
		vec_t                  v;
		cpu_pkg::wb_event_t    exp_wb;
		cpu_pkg::store_event_t exp_st;
		bit                    seen;
		int                    errs;
		errs = 0;
		for (int i = 0; i < VEC_DEPTH; i++) begin
			v = vec_mem[i];
			if (int'(v.test) == t && v.kind == KIND_WB) begin
				exp_wb = '{wreg: v.a[4:0], wdata: v.b};
				wait_for_wb(seen);
				if (!seen) begin
					$display("test %0d: write of %h to r%0d never appeared",
						t, exp_wb.wdata, exp_wb.wreg);
					errs++;
				end else begin
					check_wb(exp_wb, wb_q.pop_front(), t, errs);
				end
			end
		end
		for (int i = 0; i < VEC_DEPTH; i++) begin
			v = vec_mem[i];
			if (int'(v.test) == t && v.kind == KIND_STORE) begin
				exp_st = '{addr: v.a, data: v.b};
				wait_for_store(seen);
				if (!seen) begin
					$display("test %0d: store of %h to address %h never appeared",
						t, exp_st.data, exp_st.addr);
					errs++;
				end else begin
					check_store(exp_st, store_q.pop_front(), t, errs);
				end
			end
		end
		if (errs == 0) begin
			pass_count++;
		end else begin
			fail_count++;
		end
		$display("test %0d (%s): %s, %0d errors", t, test_name(t),
			(errs == 0) ? "passed" : "failed", errs);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int prog_words;
		int stray;
		rst_n          = 1'b0;
		imem_load_en   = 1'b0;
		imem_load_addr = '0;
		imem_load_data = '0;
		pass_count     = 0;
		fail_count     = 0;
		stray          = 0;
		for (int i = 0; i < VEC_DEPTH; i++) begin
			vec_mem[i] = '0;
		end
		$readmemh("dv/cpu_vectors.txt", vec_mem);

		// Program goes in while the core is held, then reset runs its 8 cycles
		load_program(prog_words);
		if (prog_words == 0) begin
			$display("vector file holds no program words");
			fail_count++;
		end
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;

		for (int t = 1; t <= NUM_TESTS; t++) begin
			run_test(t);
		end

		// Program ends in a self loop, nothing more may retire
		repeat (DRAIN_CYCLES) @(posedge clk);
		stray = wb_q.size() + store_q.size();
		if (stray != 0) begin
			$display("%0d register writes and %0d stores appeared that no test expected",
				wb_q.size(), store_q.size());
		end

		$display("tests passed: %0d, failed: %0d, unexpected events: %0d",
			pass_count, fail_count, stray);
		if (fail_count == 0 && stray == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
hdl/cpu_pkg.sv
hdl/pipe_reg.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/fwd_unit.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/ram.sv
hdl/cpu.sv
dv/cpu_tb.sv

//--- Bender.yml
package:
  name: mips_pipe_cpu

sources:
  - hdl/cpu_pkg.sv
  - hdl/pipe_reg.sv
  - hdl/decoder.sv
  - hdl/regfile.sv
  - hdl/fwd_unit.sv
  - hdl/alu.sv
  - hdl/branch_unit.sv
  - hdl/ram.sv
  - hdl/cpu.sv
  - target: test
    files:
      - dv/cpu_tb.sv

//--- dv/cpu_vectors.txt
// Columns: kind _ test _ a _ b, all hex
// kind 1 program (a address, b instruction), 2 write (a register, b value), 3 store (a address, b data)
// Test 1: addiu, lui, addu, subu, and, or, slt, sll
1_1_00000000_24010005
1_1_00000004_2402fffd
1_1_00000008_3c031234
1_1_0000000c_240400f0
1_1_00000010_00222821
1_1_00000014_00223023
1_1_00000018_00443824
1_1_0000001c_00644025
1_1_00000020_0041482a
1_1_00000024_0022502a
1_1_00000028_00015900
2_1_00000001_00000005
2_1_00000002_fffffffd
2_1_00000003_12340000
2_1_00000004_000000f0
2_1_00000005_00000002
2_1_00000006_00000008
2_1_00000007_000000f0
2_1_00000008_123400f0
2_1_00000009_00000001
2_1_0000000a_00000000
2_1_0000000b_00000050
// Test 2: dependent chains at EX, MEM and WB distance, youngest writer wins
1_2_0000002c_240c0007
1_2_00000030_018c6821
1_2_00000034_01ac7021
1_2_00000038_01cc7823
1_2_0000003c_25b00001
1_2_00000040_01ee8825
1_2_00000044_24120001
1_2_00000048_26520002
1_2_0000004c_26520004
1_2_00000050_02529821
2_2_0000000c_00000007
2_2_0000000d_0000000e
2_2_0000000e_00000015
2_2_0000000f_0000000e
2_2_00000010_0000000f
2_2_00000011_0000001f
2_2_00000012_00000001
2_2_00000012_00000003
2_2_00000012_00000007
2_2_00000013_0000000e
// Test 3: two stores, a load, load data forwarded from MEM two slots later
1_3_00000054_24140040
1_3_00000058_ae930008
1_3_0000005c_ae91000c
1_3_00000060_8e950008
1_3_00000064_24160099
1_3_00000068_02b0b821
2_3_00000014_00000040
2_3_00000015_0000000e
2_3_00000016_00000099
2_3_00000017_0000001d
3_3_00000048_0000000e
3_3_0000004c_0000001f
// Test 4: taken beq skips two writes of 0bad, not-taken beq falls through
1_4_0000006c_10210002
1_4_00000070_24180bad
1_4_00000074_24180bad
1_4_00000078_24180011
1_4_0000007c_10220001
1_4_00000080_24190022
2_4_00000018_00000011
2_4_00000019_00000022
// Test 5: jal to 0x98, jr r31 back to 0x88, then j to 0xa8
1_5_00000084_0c000026
1_5_00000088_241a0033
1_5_0000008c_0800002a
1_5_00000090_241a0bad
1_5_00000094_241a0bad
1_5_00000098_241b0044
1_5_0000009c_03e00008
1_5_000000a0_241b0bad
1_5_000000a4_241b0bad
2_5_0000001f_00000088
2_5_0000001b_00000044
2_5_0000001a_00000033
// Test 6: write to r0 is hidden and r0 still reads zero, then a self loop
1_6_000000a8_24000055
1_6_000000ac_241c0066
1_6_000000b0_0000e821
1_6_000000b4_0800002d
1_6_000000b8_00000000
1_6_000000bc_00000000
2_6_0000001c_00000066
2_6_0000001d_00000000
